// File: lsu_top.f
rtl/lsu_pkg.sv
rtl/wb_pkg.sv
rtl/dwb_if.sv
rtl/lsu_decode.sv
rtl/dwb_master.sv
rtl/load_align.sv
rtl/data_ram.sv
rtl/lsu_top.sv
test/lsu_checker.sv
test/lsu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module lsu_tb -f lsu_top.f -o lsu_sim || exit 1
out=$(./obj_dir/lsu_sim)
echo "$out"
echo "$out" | grep -q "RESULT: PASS" && exit 0 || exit 1

// File: test/lsu_tb.sv
// Load/store unit testbench
// Clock, reset, random load and store commands and the run limit
`timescale 1ns/1ps

module lsu_tb;
   import lsu_pkg::*;

   localparam int RST_CYCLES = 10;
   // About 600 commands of at most 6 cycles each plus slack
   localparam int MAX_CMDS   = 600;
   localparam int CMD_CYCLES = 6;
   localparam int CYC_LIMIT  = RST_CYCLES + MAX_CMDS * CMD_CYCLES + 390;
   // Register form with rb as r3 and reserved bits clear
   localparam logic [15:0] RB_FIELD = {5'd3, 11'd0};

   logic        gclk;
   logic        grst;
   logic        cmd_valid_i;
   logic        cmd_ready_o;
   logic [31:0] insn_i;
   logic [31:0] ra_val_i;
   logic [31:0] rb_val_i;
   logic [31:0] rd_val_i;
   logic        res_valid_o;
   logic [31:0] res_data_o;
   logic        res_err_o;
   logic [3:0]  test_id;
   logic [31:0] rng;
   logic [31:0] word_q[$];
   int          cycles;
   int          sent;
   int          err_cnt;
   int          chk_cnt;

   lsu_top i_dut (
      .gclk        (gclk),
      .grst        (grst),
      .cmd_valid_i (cmd_valid_i),
      .cmd_ready_o (cmd_ready_o),
      .insn_i      (insn_i),
      .ra_val_i    (ra_val_i),
      .rb_val_i    (rb_val_i),
      .rd_val_i    (rd_val_i),
      .res_valid_o (res_valid_o),
      .res_data_o  (res_data_o),
      .res_err_o   (res_err_o)
   );

   lsu_checker i_checker (
      .gclk        (gclk),
      .grst        (grst),
      .test_id_i   (test_id),
      .cmd_valid_i (cmd_valid_i),
      .cmd_ready_i (cmd_ready_o),
      .insn_i      (insn_i),
      .ra_val_i    (ra_val_i),
      .rb_val_i    (rb_val_i),
      .rd_val_i    (rd_val_i),
      .res_valid_i (res_valid_o),
      .res_data_i  (res_data_o),
      .res_err_i   (res_err_o),
      .err_cnt_o   (err_cnt),
      .chk_cnt_o   (chk_cnt)
   );

   initial begin
      gclk = 1'b0;
      forever #2 gclk = ~gclk;
   end

   function automatic logic [31:0] lcg_next();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   // Upper generator bits are the better ones
   function automatic logic [15:0] rand_imm();
      logic [31:0] r;
      r = lcg_next();
      return r[31:16];
   endfunction

   function automatic logic [31:0] make_insn(input logic store, input logic imm,
                                             input size_e size, input logic [15:0] low);
      opc_t opc;
      opc.cls   = OPC_CLS_MEM;
      opc.imm   = imm;
      opc.store = store;
      opc.size  = size;
      return {opc, 10'd0, low};
   endfunction

   // Called 1 ns after an edge and returns 1 ns after the accepting edge
   task automatic send_cmd(input logic [31:0] insn, ra, rb, rd);
      while (cmd_ready_o !== 1'b1) begin
         @(posedge gclk);
         #1;
      end
      cmd_valid_i = 1'b1;
      insn_i      = insn;
      ra_val_i    = ra;
      rb_val_i    = rb;
      rd_val_i    = rd;
      @(posedge gclk);
      #1;
      cmd_valid_i = 1'b0;
      sent++;
   endtask

   // Random ra with rb making up the target address
   task automatic access_reg(input logic store, input size_e size,
                             input logic [31:0] addr, input logic [31:0] data);
      logic [31:0] ra;
      ra = lcg_next();
      send_cmd(make_insn(store, 1'b0, size, RB_FIELD), ra, addr - ra, data);
   endtask

   task automatic access_imm(input logic store, input size_e size, input logic [31:0] addr,
                             input logic [15:0] imm, input logic [31:0] data);
      send_cmd(make_insn(store, 1'b1, size, imm), addr - {{16{imm[15]}}, imm},
               lcg_next(), data);
   endtask

   initial begin
      int          i;
      int          k;
      logic [31:0] base;
      rng         = 32'd83;
      sent        = 0;
      test_id     = 4'd0;
      grst        = 1'b1;
      cmd_valid_i = 1'b0;
      insn_i      = '0;
      ra_val_i    = '0;
      rb_val_i    = '0;
      rd_val_i    = '0;
      repeat (RST_CYCLES) @(posedge gclk);
      #1;
      grst = 1'b0;

      test_id = 4'd1;
      for (i = 0; i < 256; i++) begin
         access_reg(1'b1, SZ_WORD, 32'(i) << 2, 32'h0);
      end

      test_id = 4'd2;
      for (i = 0; i < 64; i++) begin
         word_q.push_back(lcg_next() & ~32'h3);
         access_reg(1'b1, SZ_WORD, word_q[i], lcg_next());
      end
      for (i = 0; i < 64; i++) begin
         access_reg(1'b0, SZ_WORD, word_q[i], 32'h0);
      end

      // Four byte stores then the whole word
      test_id = 4'd3;
      for (i = 0; i < 8; i++) begin
         base = lcg_next() & ~32'h3;
         for (k = 0; k < 4; k++) begin
            access_reg(1'b1, SZ_BYTE, base + 32'(k), lcg_next());
         end
         access_reg(1'b0, SZ_WORD, base, 32'h0);
      end

      test_id = 4'd4;
      for (i = 0; i < 8; i++) begin
         base = lcg_next() & ~32'h3;
         access_reg(1'b1, SZ_WORD, base, lcg_next());
         access_reg(1'b0, SZ_HALF, base, 32'h0);
         access_imm(1'b0, SZ_HALF, base + 32'd2, rand_imm(), 32'h0);
         for (k = 0; k < 4; k++) begin
            access_reg(1'b0, SZ_BYTE, base + 32'(k), 32'h0);
         end
      end

      // Same word through both address forms
      test_id = 4'd5;
      for (i = 0; i < 16; i++) begin
         base = lcg_next() & ~32'h3;
         access_imm(1'b1, SZ_WORD, base, rand_imm(), lcg_next());
         access_reg(1'b0, SZ_WORD, base, 32'h0);
         access_reg(1'b1, SZ_WORD, base, lcg_next());
         access_imm(1'b0, SZ_WORD, base, 16'h8000 | rand_imm(), 32'h0);
      end

      // Rejected accesses then the untouched word
      test_id = 4'd6;
      for (i = 0; i < 8; i++) begin
         base = lcg_next() & ~32'h3;
         access_reg(1'b1, SZ_WORD, base, lcg_next());
         access_reg(1'b1, SZ_WORD, base + 32'(1 + i % 3), lcg_next());
         access_imm(1'b1, SZ_HALF, base + ((i % 2 != 0) ? 32'd3 : 32'd1), rand_imm(),
                    lcg_next());
         access_reg(1'b0, SZ_HALF, base + 32'd1, 32'h0);
         access_imm(1'b0, SZ_WORD, base + 32'd2, rand_imm(), 32'h0);
         access_reg(1'b0, SZ_WORD, base, 32'h0);
      end

      // Let the last result drain
      while (cmd_ready_o !== 1'b1) begin
         @(posedge gclk);
         #1;
      end
      repeat (4) @(posedge gclk);
      if (chk_cnt != sent) begin
         $display("Sent %0d commands but only %0d results were checked", sent, chk_cnt);
      end
      $display("Commands: %0d, checked: %0d, errors: %0d", sent, chk_cnt, err_cnt);
      if (err_cnt == 0 && chk_cnt == sent) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   // Run limit
   initial begin
      cycles = 0;
      while (cycles < CYC_LIMIT) begin
         @(posedge gclk);
         cycles++;
      end
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: test/lsu_checker.sv
// Load/store unit response checker
// Byte-level memory model, reference results and a compare on every result
`timescale 1ns/1ps

module lsu_checker (
   input  logic        gclk,
   input  logic        grst,
   input  logic [3:0]  test_id_i,
   input  logic        cmd_valid_i,
   input  logic        cmd_ready_i,
   input  logic [31:0] insn_i,
   input  logic [31:0] ra_val_i,
   input  logic [31:0] rb_val_i,
   input  logic [31:0] rd_val_i,
   input  logic        res_valid_i,
   input  logic [31:0] res_data_i,
   input  logic        res_err_i,
   output int          err_cnt_o,
   output int          chk_cnt_o
);
   import lsu_pkg::*;
   import wb_pkg::*;

   // Result latency in cycles after acceptance
   localparam int LAT_BUS = 5;
   localparam int LAT_ERR = 1;
   localparam int LAT_MAX = 8;
   // Byte index width of the model
   localparam int MB_AW   = RAM_AW + 2;

   logic [7:0]  mem_b [0:(1 << MB_AW)-1];
   logic        pend = 1'b0;
   logic        rst_q = 1'b0;
   logic [32:0] exp_res;
   logic [3:0]  cmd_test;
   int          exp_lat;
   int          age;
   int          errs = 0;
   int          checks = 0;

   assign err_cnt_o = errs;
   assign chk_cnt_o = checks;

   function automatic string test_name(input logic [3:0] id);
      case (id)
         4'd0:    return "reset";
         4'd1:    return "ram_clear";
         4'd2:    return "word_rw";
         4'd3:    return "byte_order";
         4'd4:    return "narrow_load";
         4'd5:    return "imm_form";
         default: return "misalign";
      endcase
   endfunction

   // Upper address bits wrap around the RAM
   function automatic logic [MB_AW-1:0] byte_idx(input logic [31:0] a);
      return a[MB_AW-1:0];
   endfunction

   // ra plus rb or plus the sign-extended immediate
   function automatic logic [31:0] eff_addr(input logic [31:0] insn, ra, rb);
      opc_t opc;
      opc = opc_t'(insn[31:26]);
      return opc.imm ? ra + {{16{insn[15]}}, insn[15:0]} : ra + rb;
   endfunction

   function automatic logic misaligned(input size_e size, input logic [31:0] a);
      return (size == SZ_HALF && a[0]) || (size == SZ_WORD && a[1:0] != 2'b00);
   endfunction

   // Expected error flag over data with offset 0 as the most significant byte
   function automatic logic [32:0] ref_result(input logic [31:0] insn, ra, rb);
      opc_t        opc;
      logic [31:0] a;
      opc = opc_t'(insn[31:26]);
      a   = eff_addr(insn, ra, rb);
      if (misaligned(opc.size, a)) begin
         return {1'b1, 32'h0};
      end
      if (opc.store) begin
         return {1'b0, 32'h0};
      end
      case (opc.size)
         SZ_BYTE: return {1'b0, 24'h0, mem_b[byte_idx(a)]};
         SZ_HALF: return {1'b0, 16'h0, mem_b[byte_idx(a)], mem_b[byte_idx(a + 32'd1)]};
         default: return {1'b0, mem_b[byte_idx(a)], mem_b[byte_idx(a + 32'd1)],
                          mem_b[byte_idx(a + 32'd2)], mem_b[byte_idx(a + 32'd3)]};
      endcase
   endfunction

   task automatic store_model(input logic [31:0] insn, ra, rb, rd);
      opc_t        opc;
      logic [31:0] a;
      opc = opc_t'(insn[31:26]);
      a   = eff_addr(insn, ra, rb);
      // Misaligned stores never reach memory
      if (opc.store && !misaligned(opc.size, a)) begin
         case (opc.size)
            SZ_BYTE: mem_b[byte_idx(a)] = rd[7:0];
            SZ_HALF: begin
               mem_b[byte_idx(a)]          = rd[15:8];
               mem_b[byte_idx(a + 32'd1)]  = rd[7:0];
            end
            default: begin
               mem_b[byte_idx(a)]          = rd[31:24];
               mem_b[byte_idx(a + 32'd1)]  = rd[23:16];
               mem_b[byte_idx(a + 32'd2)]  = rd[15:8];
               mem_b[byte_idx(a + 32'd3)]  = rd[7:0];
            end
         endcase
      end
   endtask

   task automatic flag_mismatch(input logic [3:0] id, input string what,
                                input logic [31:0] exp, input logic [31:0] act);
      $display("[ERROR] %s %s: expected %h, actual %h", test_name(id), what, exp, act);
      errs++;
   endtask

   always @(posedge gclk) begin
      if (grst) begin
         pend = 1'b0;
         age  = 0;
      end else begin
         // Idle outputs right after reset
         if (rst_q) begin
            if (cmd_ready_i !== 1'b1) begin
               flag_mismatch(4'd0, "ready", 32'd1, {31'h0, cmd_ready_i});
            end
            if (res_valid_i !== 1'b0) begin
               flag_mismatch(4'd0, "valid", 32'd0, {31'h0, res_valid_i});
            end
            if (res_err_i !== 1'b0) begin
               flag_mismatch(4'd0, "err", 32'd0, {31'h0, res_err_i});
            end
         end
         if (pend) begin
            age++;
         end
         if (res_valid_i) begin
            if (!pend) begin
               $display("Result seen with no command pending in test %s",
                        test_name(test_id_i));
               errs++;
            end else begin
               checks++;
               if (res_data_i !== exp_res[31:0]) begin
                  flag_mismatch(cmd_test, "data", exp_res[31:0], res_data_i);
               end
               if (res_err_i !== exp_res[32]) begin
                  flag_mismatch(cmd_test, "err", {31'h0, exp_res[32]}, {31'h0, res_err_i});
               end
               // Outputs show up on the edge after they rise
               if (age - 1 != exp_lat) begin
                  flag_mismatch(cmd_test, "latency", exp_lat, age - 1);
               end
               // Ready comes back together with the result
               if (cmd_ready_i !== 1'b1) begin
                  flag_mismatch(cmd_test, "ready", 32'd1, {31'h0, cmd_ready_i});
               end
               pend = 1'b0;
            end
         end else if (pend) begin
            // Busy while the command is in flight
            if (cmd_ready_i !== 1'b0) begin
               flag_mismatch(cmd_test, "ready", 32'd0, {31'h0, cmd_ready_i});
            end
            if (age - 1 > LAT_MAX) begin
               $display("No result within %0d cycles of acceptance in test %s",
                        LAT_MAX, test_name(cmd_test));
               errs++;
               pend = 1'b0;
            end
         end
         // New command taken on this edge
         if (cmd_valid_i && cmd_ready_i) begin
            exp_res  = ref_result(insn_i, ra_val_i, rb_val_i);
            exp_lat  = exp_res[32] ? LAT_ERR : LAT_BUS;
            cmd_test = test_id_i;
            store_model(insn_i, ra_val_i, rb_val_i, rd_val_i);
            pend = 1'b1;
            age  = 0;
         end
      end
      rst_q = grst;
   end

endmodule

// File: rtl/lsu_top.sv
// Load/store unit top
// Command decode, Wishbone data master, load aligner and data RAM
`timescale 1ns/1ps

module lsu_top (
   input  logic                      gclk,
   input  logic                      grst,
   input  logic                      cmd_valid_i,
   output logic                      cmd_ready_o,
   input  logic [31:0]               insn_i,
   input  logic [wb_pkg::DWB_DW-1:0] ra_val_i,
   input  logic [wb_pkg::DWB_DW-1:0] rb_val_i,
   input  logic [wb_pkg::DWB_DW-1:0] rd_val_i,
   output logic                      res_valid_o,
   output logic [wb_pkg::DWB_DW-1:0] res_data_o,
   output logic                      res_err_o
);
   import lsu_pkg::*;
   import wb_pkg::*;

   mem_cmd_t          cmd;
   logic              go;
   logic              done;
   logic              misalign;
   logic [DWB_DW-1:0] rdat;
   logic [DWB_SW-1:0] rsel;

   dwb_if dwb ();

   lsu_decode i_decode (
      .gclk        (gclk),
      .grst        (grst),
      .cmd_valid_i (cmd_valid_i),
      .cmd_ready_o (cmd_ready_o),
      .insn_i      (insn_i),
      .ra_val_i    (ra_val_i),
      .rb_val_i    (rb_val_i),
      .rd_val_i    (rd_val_i),
      .cmd_o       (cmd),
      .go_o        (go),
      .misalign_o  (misalign),
      .done_i      (done)
   );

   dwb_master i_master (
      .gclk   (gclk),
      .grst   (grst),
      .cmd_i  (cmd),
      .go_i   (go),
      .dwb    (dwb.master),
      .done_o (done),
      .rdat_o (rdat),
      .rsel_o (rsel)
   );

   // Store flag stays valid until the next command
   load_align i_align (
      .gclk        (gclk),
      .grst        (grst),
      .done_i      (done),
      .rdat_i      (rdat),
      .rsel_i      (rsel),
      .is_store_i  (cmd.store),
      .misalign_i  (misalign),
      .res_valid_o (res_valid_o),
      .res_data_o  (res_data_o),
      .res_err_o   (res_err_o)
   );

   data_ram i_ram (
      .gclk (gclk),
      .grst (grst),
      .dwb  (dwb.slave)
   );

endmodule

// File: rtl/data_ram.sv
// On-chip data RAM
// Wishbone slave with byte write enables and one wait state
`timescale 1ns/1ps

module data_ram (
   input  logic gclk,
   input  logic grst,
   dwb_if.slave dwb
);
   import wb_pkg::*;

   logic [DWB_DW-1:0] mem [0:RAM_DEPTH-1];
   logic [RAM_AW-1:0] idx;
   logic              seen;

   // Word index, upper address bits wrap
   assign idx = dwb.adr[RAM_AW+1:2];

   // Ack in the second strobe cycle
   assign dwb.ack = dwb.stb & dwb.cyc & seen;

   always_ff @(posedge gclk) begin
      if (grst) begin
         seen <= 1'b0;
      end else begin
         // Set for one cycle after the first strobe cycle
         seen <= dwb.stb & dwb.cyc & ~seen;
      end
   end

   // Read word ready by the ack cycle
   always_ff @(posedge gclk) begin
      dwb.dat_s <= mem[idx];
   end

   // Byte writes, lane 3 is bits 31:24
   always_ff @(posedge gclk) begin
      if (dwb.ack & dwb.we) begin
         for (int b = 0; b < DWB_SW; b++) begin
            if (dwb.sel[b]) begin
               mem[idx][b*8 +: 8] <= dwb.dat_m[b*8 +: 8];
            end
         end
      end
   end

endmodule

// File: rtl/load_align.sv
// Load data aligner
// Moves the selected lanes to the low end, zero-extends and registers the result
`timescale 1ns/1ps

module load_align (
   input  logic                      gclk,
   input  logic                      grst,
   input  logic                      done_i,
   input  logic [wb_pkg::DWB_DW-1:0] rdat_i,
   input  logic [wb_pkg::DWB_SW-1:0] rsel_i,
   input  logic                      is_store_i,
   input  logic                      misalign_i,
   output logic                      res_valid_o,
   output logic [wb_pkg::DWB_DW-1:0] res_data_o,
   output logic                      res_err_o
);
   import wb_pkg::*;

   logic [DWB_DW-1:0] lane;

   // Big-endian, offset 0 is the top byte
   always_comb begin
      case (rsel_i)
         SEL_WORD: lane = rdat_i;
         SEL_HI:   lane = {16'h0, rdat_i[31:16]};
         SEL_LO:   lane = {16'h0, rdat_i[15:0]};
         SEL_B0:   lane = {24'h0, rdat_i[31:24]};
         SEL_B1:   lane = {24'h0, rdat_i[23:16]};
         SEL_B2:   lane = {24'h0, rdat_i[15:8]};
         SEL_B3:   lane = {24'h0, rdat_i[7:0]};
         default:  lane = '0;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         res_valid_o <= 1'b0;
         res_err_o   <= 1'b0;
         res_data_o  <= '0;
      end else begin
         // One-cycle result, bus completion or early error
         res_valid_o <= done_i | misalign_i;
         res_err_o   <= misalign_i;
         // Only loads carry data back
         res_data_o  <= (done_i & ~is_store_i) ? lane : '0;
      end
   end

endmodule

// File: rtl/dwb_master.sv
// Wishbone data master
// Sizes store data, drives big-endian selects and latches read data on ack
`timescale 1ns/1ps

module dwb_master (
   input  logic                       gclk,
   input  logic                       grst,
   input  lsu_pkg::mem_cmd_t          cmd_i,
   input  logic                       go_i,
   dwb_if.master                      dwb,
   output logic                       done_o,
   output logic [wb_pkg::DWB_DW-1:0]  rdat_o,
   output logic [wb_pkg::DWB_SW-1:0]  rsel_o
);
   import lsu_pkg::*;
   import wb_pkg::*;

   logic [1:0]        off;
   logic [DWB_DW-1:0] wdat;
   logic [DWB_SW-1:0] sel_n;
   logic              fin;

   assign off = cmd_i.addr[1:0];
   // Slave ack ends the cycle
   assign fin = dwb.stb & dwb.ack;

   // Store operand copied across lanes
   always_comb begin
      case (cmd_i.size)
         SZ_BYTE: wdat = {4{cmd_i.wdat[7:0]}};
         SZ_HALF: wdat = {2{cmd_i.wdat[15:0]}};
         default: wdat = cmd_i.wdat;
      endcase
   end

   // Size and offset to byte lanes
   always_comb begin
      case (cmd_i.size)
         SZ_BYTE: begin
            case (off)
               2'd0:    sel_n = SEL_B0;
               2'd1:    sel_n = SEL_B1;
               2'd2:    sel_n = SEL_B2;
               default: sel_n = SEL_B3;
            endcase
         end
         // Halves are aligned, bit 1 picks the half
         SZ_HALF: sel_n = off[1] ? SEL_LO : SEL_HI;
         default: sel_n = SEL_WORD;
      endcase
   end

   // Cycle control
   always_ff @(posedge gclk) begin
      if (grst) begin
         dwb.stb <= 1'b0;
         dwb.cyc <= 1'b0;
         dwb.we  <= 1'b0;
         dwb.sel <= '0;
         done_o  <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (go_i) begin
            dwb.stb <= 1'b1;
            dwb.cyc <= 1'b1;
            dwb.we  <= cmd_i.store;
            dwb.sel <= sel_n;
         end else if (fin) begin
            // Drop the cycle on the ack edge
            dwb.stb <= 1'b0;
            dwb.cyc <= 1'b0;
            dwb.we  <= 1'b0;
            dwb.sel <= '0;
            done_o  <= 1'b1;
         end
      end
   end

   // Address and data held stable until ack
   always_ff @(posedge gclk) begin
      if (go_i) begin
         dwb.adr   <= cmd_i.addr[DWB_AW-1:2];
         dwb.dat_m <= wdat;
      end
      if (fin) begin
         rdat_o <= dwb.dat_s;
         rsel_o <= dwb.sel;
      end
   end

endmodule

// File: rtl/lsu_decode.sv
// Load/store command decode
// Takes one command, forms the effective address and rejects misaligned access
`timescale 1ns/1ps

module lsu_decode (
   input  logic              gclk,
   input  logic              grst,
   input  logic              cmd_valid_i,
   output logic              cmd_ready_o,
   input  logic [31:0]       insn_i,
   input  logic [31:0]       ra_val_i,
   input  logic [31:0]       rb_val_i,
   input  logic [31:0]       rd_val_i,
   output lsu_pkg::mem_cmd_t cmd_o,
   output logic              go_o,
   output logic              misalign_o,
   input  logic              done_i
);
   import lsu_pkg::*;

   logic        take;
   logic        pend;
   opc_t        opc_q;
   insn_low_u   low_q;
   logic [31:0] ra_q;
   logic [31:0] rb_q;
   logic [31:0] rd_q;
   logic [31:0] offs;
   logic [31:0] addr;
   logic        mis;
   logic        bad;

   assign take = cmd_valid_i & cmd_ready_o;

   always_comb begin
      // Immediate form sign-extends the low half
      offs = opc_q.imm ? {{16{low_q.imm[15]}}, low_q.imm} : rb_q;
      addr = ra_q + offs;
      case (opc_q.size)
         SZ_BYTE: mis = 1'b0;
         SZ_HALF: mis = addr[0];
         default: mis = |addr[1:0];
      endcase
      // Non-memory opcodes and dirty reserved bits are rejected too
      bad = mis | (opc_q.cls != OPC_CLS_MEM) | (~opc_q.imm & (|low_q.r.rsvd));
   end

   // Error pulse in the cycle after acceptance
   assign misalign_o = pend & bad;

   always_ff @(posedge gclk) begin
      if (grst) begin
         pend        <= 1'b0;
         go_o        <= 1'b0;
         cmd_ready_o <= 1'b1;
      end else begin
         pend <= take;
         go_o <= pend & ~bad;
         // Busy until the result goes out
         if (take) begin
            cmd_ready_o <= 1'b0;
         end else if (done_i | misalign_o) begin
            cmd_ready_o <= 1'b1;
         end
      end
   end

   // Command operands
   always_ff @(posedge gclk) begin
      if (take) begin
         opc_q <= opc_t'(insn_i[OPC_LSB +: OPC_W]);
         low_q <= insn_i[LOW_W-1:0];
         ra_q  <= ra_val_i;
         rb_q  <= rb_val_i;
         rd_q  <= rd_val_i;
      end
      if (pend) begin
         cmd_o.addr  <= addr;
         cmd_o.store <= opc_q.store;
         cmd_o.size  <= opc_q.size;
         cmd_o.wdat  <= rd_q;
      end
   end

endmodule

// File: rtl/dwb_if.sv
// Wishbone classic data bus
// Master drives the cycle, slave returns read data and ack
`timescale 1ns/1ps

interface dwb_if;
   import wb_pkg::*;

   logic [DWB_AW-1:2] adr;    // Word address
   logic [DWB_DW-1:0] dat_m;  // Write data
   logic [DWB_DW-1:0] dat_s;  // Read data
   logic [DWB_SW-1:0] sel;
   logic              we;
   logic              stb;
   logic              cyc;
   logic              ack;

   modport master (
      output adr, dat_m, sel, we, stb, cyc,
      input  dat_s, ack
   );

   modport slave (
      input  adr, dat_m, sel, we, stb, cyc,
      output dat_s, ack
   );

endinterface

// File: rtl/wb_pkg.sv
// Data bus package
// Wishbone data bus widths, big-endian byte selects and RAM size
package wb_pkg;

   // Byte address width, bus carries only the word part
   localparam int DWB_AW = 32;
   localparam int DWB_DW = 32;
   localparam int DWB_SW = DWB_DW / 8;

   // Byte selects, offset 0 on bit 3
   localparam logic [3:0] SEL_WORD = 4'hF;
   localparam logic [3:0] SEL_HI   = 4'hC;
   localparam logic [3:0] SEL_LO   = 4'h3;
   localparam logic [3:0] SEL_B0   = 4'h8;
   localparam logic [3:0] SEL_B1   = 4'h4;
   localparam logic [3:0] SEL_B2   = 4'h2;
   localparam logic [3:0] SEL_B3   = 4'h1;

   // Word index width of the data RAM
   localparam int RAM_AW    = 8;
   localparam int RAM_DEPTH = 1 << RAM_AW;

endpackage

// File: rtl/lsu_pkg.sv
// Load/store unit package
// Instruction field layout, opcode classes, access sizes and the decoded command
package lsu_pkg;

   // Opcode sits in the top six bits
   localparam int OPC_LSB = 26;
   localparam int OPC_W   = 6;
   // Low half holds rb or a 16-bit immediate
   localparam int LOW_W   = 16;

   // Both class bits set for loads and stores
   localparam logic [1:0] OPC_CLS_MEM = 2'b11;

   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_e;

   typedef struct packed {
      logic [1:0] cls;
      logic       imm;    // Immediate form
      logic       store;  // Store, else load
      size_e      size;
   } opc_t;

   // Register form of the low half
   typedef struct packed {
      logic [4:0]  rb;
      logic [10:0] rsvd;
   } insn_reg_t;

   typedef union packed {
      insn_reg_t        r;
      logic [LOW_W-1:0] imm;
   } insn_low_u;

   typedef struct packed {
      logic [31:0] addr;
      logic        store;
      size_e       size;
      logic [31:0] wdat;
   } mem_cmd_t;

endpackage
